//--- all.f
verilog/isa_pkg.sv
verilog/datapath_pkg.sv
verilog/issue_decode.sv
verilog/scalar_lane.sv
verilog/vector_lane.sv
verilog/writeback_merge.sv
verilog/simd_core_top.sv
verification/simd_core_tb.sv

//--- verification/simd_core_tb.sv
module simd_core_tb;

	localparam int NUM_LANES    = 16;
	localparam int EW           = datapath_pkg::ELEM_W;
	localparam int VEC_W        = NUM_LANES * EW;
	localparam int DRAIN_LIMIT  = 20;
	localparam int RANDOM_COUNT = 200;

	typedef struct packed {
		logic [isa_pkg::REG_ADDR_W-1:0] rd;
		logic                           is_vector;
		logic [EW-1:0]                  scalar;
		logic [VEC_W-1:0]               vector;
	} expect_t;

	logic                           clk;
	logic                           rst_n;
	logic                           issue;
	isa_pkg::op_e                   op;
	logic [isa_pkg::REG_ADDR_W-1:0] rd;
	logic [isa_pkg::REG_ADDR_W-1:0] rs1;
	logic [isa_pkg::REG_ADDR_W-1:0] rs2;
	logic [isa_pkg::IMM_W-1:0]      imm;
	logic                           result_valid;
	logic                           result_is_vector;
	logic [isa_pkg::REG_ADDR_W-1:0] result_rd;
	logic [EW-1:0]                  result_scalar;
	logic [VEC_W-1:0]               result_vector;

	// Reference model state updated at issue in program order
	logic [EW-1:0]    model_s [8];
	logic [VEC_W-1:0] model_v [8];
	expect_t          exp_q [$];

	logic [15:0] lfsr_state    = 16'd90;
	logic        issued_d1     = 1'b0;
	logic        issued_d2     = 1'b0;
	logic        reset_applied = 1'b0;
	int          errors        = 0;
	int          tests_passed  = 0;
	int          tests_failed  = 0;

	simd_core_top #(.NUM_LANES(NUM_LANES)) dut (
		.clk(clk), .rst_n(rst_n),
		.issue(issue), .op(op), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
		.result_valid(result_valid), .result_is_vector(result_is_vector),
		.result_rd(result_rd), .result_scalar(result_scalar),
		.result_vector(result_vector)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		if (!rst_n) begin
			reset_applied <= 1'b1;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	// Galois LFSR with taps at 16 14 13 11
	function automatic logic next_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b) begin
			lfsr_state = lfsr_state ^ 16'hB400;
		end
		return b;
	endfunction

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], next_bit()};
		end
		return v;
	endfunction

	// One element of the ISA's arithmetic modulo 256
	function automatic logic [EW-1:0] elem_ref(isa_pkg::op_e o, logic [EW-1:0] a,
		logic [EW-1:0] b);
		logic [EW-1:0] y;
		case (o)
			isa_pkg::OP_SADD, isa_pkg::OP_VADD: y = a + b;
			isa_pkg::OP_SSUB, isa_pkg::OP_VSUB: y = a - b;
			isa_pkg::OP_SAND, isa_pkg::OP_VAND: y = a & b;
			isa_pkg::OP_SXOR: y = a ^ b;
			default: y = b;
		endcase
		return y;
	endfunction

	task automatic report_mismatch(input string name, input logic [VEC_W-1:0] exp_val,
		input logic [VEC_W-1:0] act_val);
		$display("** Error: %s expected %h actual %h", name, exp_val, act_val);
		errors++;
	endtask

	task automatic send(input isa_pkg::op_e o, input logic [2:0] d, input logic [2:0] s1,
		input logic [2:0] s2, input logic [7:0] im);
		expect_t       e;
		logic [EW-1:0] sum;
		@(posedge clk);
		issue <= 1'b1;
		op    <= o;
		rd    <= d;
		rs1   <= s1;
		rs2   <= s2;
		imm   <= im;
		e     = '0;
		e.rd  = d;
		sum   = '0;
		case (o)
			isa_pkg::OP_SLI: e.scalar = im;
			isa_pkg::OP_SADD, isa_pkg::OP_SSUB, isa_pkg::OP_SAND, isa_pkg::OP_SXOR:
				e.scalar = elem_ref(o, model_s[s1], model_s[s2]);
			isa_pkg::OP_VBCAST: begin
				e.is_vector = 1'b1;
				for (int l = 0; l < NUM_LANES; l++) begin
					e.vector[l*EW +: EW] = model_s[s1];
				end
			end
			isa_pkg::OP_VADD, isa_pkg::OP_VSUB, isa_pkg::OP_VAND: begin
				e.is_vector = 1'b1;
				for (int l = 0; l < NUM_LANES; l++) begin
					e.vector[l*EW +: EW] = elem_ref(o, model_v[s1][l*EW +: EW],
						model_v[s2][l*EW +: EW]);
				end
			end
			isa_pkg::OP_VSUM: begin
				for (int l = 0; l < NUM_LANES; l++) begin
					sum = sum + model_v[s1][l*EW +: EW];
				end
				e.scalar = sum;
			end
			default: ;
		endcase
		if (o != isa_pkg::OP_NOP) begin
			if (e.is_vector) begin
				model_v[d] = e.vector;
			end else begin
				model_s[d] = e.scalar;
			end
			exp_q.push_back(e);
		end
	endtask

	task automatic idle();
		@(posedge clk);
		issue <= 1'b0;
	endtask

	// Wait until every expected result has retired
	task automatic drain(input string name);
		int cycles;
		cycles = 0;
		idle();
		while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout in %s: %0d results did not retire", name, exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, errors - start_errors);
		end
	endtask

	//////////////////////////////
	// Checking
	//////////////////////////////
	// Outputs are sampled at the falling edge
	always @(negedge clk) begin
		expect_t e;
		if (reset_applied) begin
			assert (result_valid === issued_d2) else
				report_mismatch("result_valid", issued_d2, result_valid);
			assert (!result_valid || exp_q.size() > 0) else begin
				$display("result_valid was high with no result pending");
				errors++;
			end
			if (result_valid && exp_q.size() > 0) begin
				e = exp_q.pop_front();
				assert (result_rd === e.rd) else
					report_mismatch("result_rd", e.rd, result_rd);
				assert (result_is_vector === e.is_vector) else
					report_mismatch("result_is_vector", e.is_vector, result_is_vector);
				assert (result_scalar === e.scalar) else
					report_mismatch("result_scalar", e.scalar, result_scalar);
				assert (result_vector === e.vector) else
					report_mismatch("result_vector", e.vector, result_vector);
			end
		end
		issued_d2 = issued_d1;
		issued_d1 = issue && (op != isa_pkg::OP_NOP);
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		int         start;
		logic [3:0] sel;
		logic [2:0] r_d;
		logic [2:0] r_s1;
		logic [2:0] r_s2;
		logic [7:0] r_imm;
		clk   = 1'b0;
		rst_n = 1'b0;
		issue = 1'b0;
		op    = isa_pkg::OP_NOP;
		rd    = '0;
		rs1   = '0;
		rs2   = '0;
		imm   = '0;
		for (int i = 0; i < 8; i++) begin
			model_s[i] = '0;
			model_v[i] = '0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		start = errors;
		idle();
		send(isa_pkg::OP_SADD, 3'd1, 3'd0, 3'd0, 8'h00);
		send(isa_pkg::OP_VSUM, 3'd2, 3'd3, 3'd0, 8'h00);
		drain("reset");
		finish_test("reset", start);

		// Each op reads the value written just before it
		start = errors;
		send(isa_pkg::OP_SLI, 3'd1, 3'd0, 3'd0, 8'h5A);
		send(isa_pkg::OP_SADD, 3'd2, 3'd1, 3'd1, 8'h00);
		send(isa_pkg::OP_SSUB, 3'd3, 3'd1, 3'd2, 8'h00);
		send(isa_pkg::OP_SAND, 3'd4, 3'd3, 3'd2, 8'h00);
		send(isa_pkg::OP_SXOR, 3'd5, 3'd4, 3'd2, 8'h00);
		drain("scalar");
		finish_test("scalar", start);

		start = errors;
		send(isa_pkg::OP_SLI, 3'd1, 3'd0, 3'd0, 8'hF0);
		send(isa_pkg::OP_SLI, 3'd2, 3'd0, 3'd0, 8'h20);
		send(isa_pkg::OP_VBCAST, 3'd1, 3'd1, 3'd0, 8'h00);
		send(isa_pkg::OP_VBCAST, 3'd2, 3'd2, 3'd0, 8'h00);
		send(isa_pkg::OP_VADD, 3'd3, 3'd1, 3'd2, 8'h00);
		send(isa_pkg::OP_VSUB, 3'd4, 3'd2, 3'd1, 8'h00);
		send(isa_pkg::OP_VAND, 3'd5, 3'd3, 3'd4, 8'h00);
		drain("vector");
		finish_test("vector", start);

		// Second sum reads v7 while scalar r7 sits in writeback
		start = errors;
		send(isa_pkg::OP_SLI, 3'd3, 3'd0, 3'd0, 8'h13);
		send(isa_pkg::OP_VBCAST, 3'd7, 3'd3, 3'd0, 8'h00);
		send(isa_pkg::OP_VSUM, 3'd7, 3'd7, 3'd0, 8'h00);
		send(isa_pkg::OP_VSUM, 3'd5, 3'd7, 3'd0, 8'h00);
		drain("reduce");
		finish_test("reduce", start);

		// Random ops over all eleven opcodes with idle gaps
		start = errors;
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			if (take_bits(2) == 8'd0) begin
				idle();
			end
			sel   = take_bits(4);
			r_d   = take_bits(3);
			r_s1  = take_bits(3);
			r_s2  = take_bits(3);
			r_imm = take_bits(8);
			send(isa_pkg::op_e'(sel % 11), r_d, r_s1, r_s2, r_imm);
		end
		drain("random");
		finish_test("random", start);

		$display("tests passed %0d, failed %0d, check errors %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/simd_core_top.sv
module simd_core_top #(
	parameter int NUM_LANES = 16
) (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      issue,
	input  isa_pkg::op_e                              op,
	input  logic [isa_pkg::REG_ADDR_W-1:0]            rd,
	input  logic [isa_pkg::REG_ADDR_W-1:0]            rs1,
	input  logic [isa_pkg::REG_ADDR_W-1:0]            rs2,
	input  logic [isa_pkg::IMM_W-1:0]                 imm,
	output logic                                      result_valid,
	output logic                                      result_is_vector,
	output logic [isa_pkg::REG_ADDR_W-1:0]            result_rd,
	output logic [datapath_pkg::ELEM_W-1:0]           result_scalar,
	output logic [NUM_LANES*datapath_pkg::ELEM_W-1:0] result_vector
);
	// Decode stage outputs
	logic                           exec_valid;
	datapath_pkg::alu_op_e          alu_op;
	logic                           use_imm;
	logic                           bcast;
	datapath_pkg::wb_src_e          wb_src;
	logic [isa_pkg::REG_ADDR_W-1:0] exec_rd;
	logic [isa_pkg::REG_ADDR_W-1:0] exec_rs1;
	logic [isa_pkg::REG_ADDR_W-1:0] exec_rs2;
	logic [isa_pkg::IMM_W-1:0]      exec_imm;
	// Lane results
	logic [datapath_pkg::ELEM_W-1:0]           scalar_a;
	logic [datapath_pkg::ELEM_W-1:0]           scalar_result;
	logic [NUM_LANES*datapath_pkg::ELEM_W-1:0] vector_result;
	logic [datapath_pkg::ELEM_W-1:0]           reduce_result;
	// Writeback and bypass
	logic                                      wb_scalar_we;
	logic                                      wb_vector_we;
	logic [isa_pkg::REG_ADDR_W-1:0]            wb_rd;
	logic [datapath_pkg::ELEM_W-1:0]           wb_scalar_data;
	logic [NUM_LANES*datapath_pkg::ELEM_W-1:0] wb_vector_data;

	//////////////////////////////
	// Decode
	//////////////////////////////
	issue_decode u_issue_decode (
		.clk(clk), .rst_n(rst_n),
		.issue(issue), .op(op), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
		.exec_valid(exec_valid), .alu_op(alu_op), .use_imm(use_imm), .bcast(bcast),
		.wb_src(wb_src), .exec_rd(exec_rd), .exec_rs1(exec_rs1), .exec_rs2(exec_rs2),
		.exec_imm(exec_imm)
	);

	//////////////////////////////
	// Execute lanes
	//////////////////////////////
	scalar_lane u_scalar_lane (
		.clk(clk), .rst_n(rst_n),
		.alu_op(alu_op), .use_imm(use_imm), .imm(exec_imm),
		.rs1(exec_rs1), .rs2(exec_rs2),
		.wb_scalar_we(wb_scalar_we), .wb_rd(wb_rd), .wb_scalar_data(wb_scalar_data),
		.scalar_a(scalar_a), .scalar_result(scalar_result)
	);

	vector_lane #(.NUM_LANES(NUM_LANES)) u_vector_lane (
		.clk(clk), .rst_n(rst_n),
		.alu_op(alu_op), .bcast(bcast),
		.rs1(exec_rs1), .rs2(exec_rs2), .scalar_a(scalar_a),
		.wb_vector_we(wb_vector_we), .wb_rd(wb_rd), .wb_vector_data(wb_vector_data),
		.vector_result(vector_result), .reduce_result(reduce_result)
	);

	//////////////////////////////
	// Writeback
	//////////////////////////////
	writeback_merge #(.NUM_LANES(NUM_LANES)) u_writeback_merge (
		.clk(clk), .rst_n(rst_n),
		.exec_valid(exec_valid), .wb_src(wb_src), .exec_rd(exec_rd),
		.scalar_result(scalar_result), .vector_result(vector_result),
		.reduce_result(reduce_result),
		.wb_scalar_we(wb_scalar_we), .wb_vector_we(wb_vector_we), .wb_rd(wb_rd),
		.wb_scalar_data(wb_scalar_data), .wb_vector_data(wb_vector_data),
		.result_valid(result_valid), .result_is_vector(result_is_vector),
		.result_rd(result_rd), .result_scalar(result_scalar),
		.result_vector(result_vector)
	);

endmodule

//--- verilog/writeback_merge.sv
module writeback_merge #(
	parameter int NUM_LANES = 16
) (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      exec_valid,
	input  datapath_pkg::wb_src_e                     wb_src,
	input  logic [isa_pkg::REG_ADDR_W-1:0]            exec_rd,
	input  logic [datapath_pkg::ELEM_W-1:0]           scalar_result,
	input  logic [NUM_LANES*datapath_pkg::ELEM_W-1:0] vector_result,
	input  logic [datapath_pkg::ELEM_W-1:0]           reduce_result,
	output logic                                      wb_scalar_we,
	output logic                                      wb_vector_we,
	output logic [isa_pkg::REG_ADDR_W-1:0]            wb_rd,
	output logic [datapath_pkg::ELEM_W-1:0]           wb_scalar_data,
	output logic [NUM_LANES*datapath_pkg::ELEM_W-1:0] wb_vector_data,
	output logic                                      result_valid,
	output logic                                      result_is_vector,
	output logic [isa_pkg::REG_ADDR_W-1:0]            result_rd,
	output logic [datapath_pkg::ELEM_W-1:0]           result_scalar,
	output logic [NUM_LANES*datapath_pkg::ELEM_W-1:0] result_vector
);
	logic [datapath_pkg::ELEM_W-1:0]           next_scalar;
	logic [NUM_LANES*datapath_pkg::ELEM_W-1:0] next_vector;

	// Pick the retiring result, the other half stays zero
	always_comb begin
		next_scalar = '0;
		next_vector = '0;
		case (wb_src)
			datapath_pkg::WB_SCALAR: next_scalar = scalar_result;
			datapath_pkg::WB_REDUCE: next_scalar = reduce_result;
			datapath_pkg::WB_VECTOR: next_vector = vector_result;
			default: ;
		endcase
	end

	//////////////////////////////
	// Writeback register
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_scalar_we   <= 1'b0;
			wb_vector_we   <= 1'b0;
			wb_rd          <= '0;
			wb_scalar_data <= '0;
			wb_vector_data <= '0;
		end else begin
			// Reduction lands in the scalar file
			wb_scalar_we   <= exec_valid && ((wb_src == datapath_pkg::WB_SCALAR) ||
				(wb_src == datapath_pkg::WB_REDUCE));
			wb_vector_we   <= exec_valid && (wb_src == datapath_pkg::WB_VECTOR);
			wb_rd          <= exec_valid ? exec_rd : '0;
			wb_scalar_data <= next_scalar;
			wb_vector_data <= next_vector;
		end
	end

	// Result ports report the entry being written this cycle
	assign result_valid     = wb_scalar_we || wb_vector_we;
	assign result_is_vector = wb_vector_we;
	assign result_rd        = wb_rd;
	assign result_scalar    = wb_scalar_data;
	assign result_vector    = wb_vector_data;

endmodule

//--- verilog/vector_lane.sv
module vector_lane #(
	parameter int NUM_LANES = 16
) (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  datapath_pkg::alu_op_e                     alu_op,
	input  logic                                      bcast,
	input  logic [isa_pkg::REG_ADDR_W-1:0]            rs1,
	input  logic [isa_pkg::REG_ADDR_W-1:0]            rs2,
	input  logic [datapath_pkg::ELEM_W-1:0]           scalar_a,
	input  logic                                      wb_vector_we,
	input  logic [isa_pkg::REG_ADDR_W-1:0]            wb_rd,
	input  logic [NUM_LANES*datapath_pkg::ELEM_W-1:0] wb_vector_data,
	output logic [NUM_LANES*datapath_pkg::ELEM_W-1:0] vector_result,
	output logic [datapath_pkg::ELEM_W-1:0]           reduce_result
);
	localparam int NUM_REGS = 2 ** isa_pkg::REG_ADDR_W;
	localparam int VEC_W    = NUM_LANES * datapath_pkg::ELEM_W;

	logic [VEC_W-1:0] vregs [NUM_REGS];
	logic [VEC_W-1:0] vec_a;
	logic [VEC_W-1:0] vec_b;
	logic [VEC_W-1:0] op_b;

	//////////////////////////////
	// Vector register file
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				vregs[i] <= '0;
			end
		end else if (wb_vector_we) begin
			vregs[wb_rd] <= wb_vector_data;
		end
	end

	// Bypass from the writeback register, same as the scalar side
	always_comb begin
		if (wb_vector_we && (wb_rd == rs1)) begin
			vec_a = wb_vector_data;
		end else begin
			vec_a = vregs[rs1];
		end
	end

	always_comb begin
		if (wb_vector_we && (wb_rd == rs2)) begin
			vec_b = wb_vector_data;
		end else begin
			vec_b = vregs[rs2];
		end
	end

	// Broadcast copies scalar rs1 into every element
	assign op_b = bcast ? {NUM_LANES{scalar_a}} : vec_b;

	//////////////////////////////
	// Lane-wise ALU
	//////////////////////////////
	// Each element wraps on its own, no carry across lanes
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			vector_result[l*datapath_pkg::ELEM_W +: datapath_pkg::ELEM_W] =
				datapath_pkg::alu_elem(
					alu_op,
					vec_a[l*datapath_pkg::ELEM_W +: datapath_pkg::ELEM_W],
					op_b[l*datapath_pkg::ELEM_W +: datapath_pkg::ELEM_W]
				);
		end
	end

	//////////////////////////////
	// Sum reduction
	//////////////////////////////
	// Accumulator is ELEM_W wide so the sum is modulo 256
	always_comb begin
		logic [datapath_pkg::ELEM_W-1:0] acc;
		acc = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			acc = acc + vec_a[l*datapath_pkg::ELEM_W +: datapath_pkg::ELEM_W];
		end
		reduce_result = acc;
	end

endmodule

//--- verilog/scalar_lane.sv
module scalar_lane (
	input  logic                           clk,
	input  logic                           rst_n,
	input  datapath_pkg::alu_op_e          alu_op,
	input  logic                           use_imm,
	input  logic [isa_pkg::IMM_W-1:0]      imm,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rs1,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rs2,
	input  logic                           wb_scalar_we,
	input  logic [isa_pkg::REG_ADDR_W-1:0] wb_rd,
	input  logic [datapath_pkg::ELEM_W-1:0] wb_scalar_data,
	output logic [datapath_pkg::ELEM_W-1:0] scalar_a,
	output logic [datapath_pkg::ELEM_W-1:0] scalar_result
);
	localparam int NUM_REGS = 2 ** isa_pkg::REG_ADDR_W;

	logic [datapath_pkg::ELEM_W-1:0] regs [NUM_REGS];
	logic [datapath_pkg::ELEM_W-1:0] src_b;
	logic [datapath_pkg::ELEM_W-1:0] op_b;

	//////////////////////////////
	// Scalar register file
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_scalar_we) begin
			regs[wb_rd] <= wb_scalar_data;
		end
	end

	// Result still in writeback wins over the stored copy
	always_comb begin
		if (wb_scalar_we && (wb_rd == rs1)) begin
			scalar_a = wb_scalar_data;
		end else begin
			scalar_a = regs[rs1];
		end
	end

	always_comb begin
		if (wb_scalar_we && (wb_rd == rs2)) begin
			src_b = wb_scalar_data;
		end else begin
			src_b = regs[rs2];
		end
	end

	//////////////////////////////
	// Operand B and ALU
	//////////////////////////////
	// SLI loads the immediate through PASS_B
	assign op_b = use_imm ? imm : src_b;

	assign scalar_result = datapath_pkg::alu_elem(alu_op, scalar_a, op_b);

endmodule

//--- verilog/issue_decode.sv
module issue_decode (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           issue,
	input  isa_pkg::op_e                   op,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rd,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rs1,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rs2,
	input  logic [isa_pkg::IMM_W-1:0]      imm,
	output logic                           exec_valid,
	output datapath_pkg::alu_op_e          alu_op,
	output logic                           use_imm,
	output logic                           bcast,
	output datapath_pkg::wb_src_e          wb_src,
	output logic [isa_pkg::REG_ADDR_W-1:0] exec_rd,
	output logic [isa_pkg::REG_ADDR_W-1:0] exec_rs1,
	output logic [isa_pkg::REG_ADDR_W-1:0] exec_rs2,
	output logic [isa_pkg::IMM_W-1:0]      exec_imm
);
	datapath_pkg::alu_op_e dec_alu_op;
	datapath_pkg::wb_src_e dec_wb_src;
	logic                  dec_use_imm;
	logic                  dec_bcast;

	//////////////////////////////
	// Opcode to lane controls
	//////////////////////////////
	always_comb begin
		dec_alu_op  = datapath_pkg::ALU_ADD;
		dec_wb_src  = datapath_pkg::WB_NONE;
		dec_use_imm = 1'b0;
		dec_bcast   = 1'b0;
		case (op)
			isa_pkg::OP_SLI: begin
				dec_alu_op  = datapath_pkg::ALU_PASS_B;
				dec_use_imm = 1'b1;
				dec_wb_src  = datapath_pkg::WB_SCALAR;
			end
			isa_pkg::OP_SADD: dec_wb_src = datapath_pkg::WB_SCALAR;
			isa_pkg::OP_SSUB: begin
				dec_alu_op = datapath_pkg::ALU_SUB;
				dec_wb_src = datapath_pkg::WB_SCALAR;
			end
			isa_pkg::OP_SAND: begin
				dec_alu_op = datapath_pkg::ALU_AND;
				dec_wb_src = datapath_pkg::WB_SCALAR;
			end
			isa_pkg::OP_SXOR: begin
				dec_alu_op = datapath_pkg::ALU_XOR;
				dec_wb_src = datapath_pkg::WB_SCALAR;
			end
			// Operand B becomes the broadcast scalar
			isa_pkg::OP_VBCAST: begin
				dec_alu_op = datapath_pkg::ALU_PASS_B;
				dec_bcast  = 1'b1;
				dec_wb_src = datapath_pkg::WB_VECTOR;
			end
			isa_pkg::OP_VADD: dec_wb_src = datapath_pkg::WB_VECTOR;
			isa_pkg::OP_VSUB: begin
				dec_alu_op = datapath_pkg::ALU_SUB;
				dec_wb_src = datapath_pkg::WB_VECTOR;
			end
			isa_pkg::OP_VAND: begin
				dec_alu_op = datapath_pkg::ALU_AND;
				dec_wb_src = datapath_pkg::WB_VECTOR;
			end
			isa_pkg::OP_VSUM: dec_wb_src = datapath_pkg::WB_REDUCE;
			default: ;
		endcase
	end

	//////////////////////////////
	// Decode register
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exec_valid <= 1'b0;
			wb_src     <= datapath_pkg::WB_NONE;
			alu_op     <= datapath_pkg::ALU_ADD;
			use_imm    <= 1'b0;
			bcast      <= 1'b0;
			exec_rd    <= '0;
			exec_rs1   <= '0;
			exec_rs2   <= '0;
			exec_imm   <= '0;
		end else begin
			// NOP decodes to WB_NONE, so it never counts as valid
			exec_valid <= issue && (dec_wb_src != datapath_pkg::WB_NONE);
			wb_src     <= issue ? dec_wb_src : datapath_pkg::WB_NONE;
			if (issue) begin
				alu_op   <= dec_alu_op;
				use_imm  <= dec_use_imm;
				bcast    <= dec_bcast;
				exec_rd  <= rd;
				exec_rs1 <= rs1;
				exec_rs2 <= rs2;
				exec_imm <= imm;
			end
		end
	end

endmodule

//--- verilog/datapath_pkg.sv
package datapath_pkg;

	// Scalar register and single vector element width
	localparam int ELEM_W = 8;

	// ALU operation shared by the scalar lane and each vector element
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_XOR    = 3'd3,
		ALU_PASS_B = 3'd4
	} alu_op_e;

	// Where the retiring result comes from
	typedef enum logic [1:0] {
		WB_NONE   = 2'd0,
		WB_SCALAR = 2'd1,
		WB_VECTOR = 2'd2,
		WB_REDUCE = 2'd3
	} wb_src_e;

	// One element of ALU work, wraps modulo 2**ELEM_W
	function automatic logic [ELEM_W-1:0] alu_elem(
		alu_op_e           op,
		logic [ELEM_W-1:0] a,
		logic [ELEM_W-1:0] b
	);
		logic [ELEM_W-1:0] y;
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_XOR: y = a ^ b;
			default: y = b;
		endcase
		return y;
	endfunction

endpackage

//--- verilog/isa_pkg.sv
package isa_pkg;

	// Register index width, eight registers per file
	localparam int REG_ADDR_W = 3;

	// Immediate field of OP_SLI
	localparam int IMM_W = 8;

	//////////////////////////////
	// Opcodes
	//////////////////////////////
	typedef enum logic [3:0] {
		// No result, nothing written
		OP_NOP    = 4'd0,
		// Scalar rd gets the immediate
		OP_SLI    = 4'd1,
		// Scalar rd gets rs1 op rs2
		OP_SADD   = 4'd2,
		OP_SSUB   = 4'd3,
		OP_SAND   = 4'd4,
		OP_SXOR   = 4'd5,
		// Every element of vector rd gets scalar rs1
		OP_VBCAST = 4'd6,
		// Element-wise on vector rs1 and rs2
		OP_VADD   = 4'd7,
		OP_VSUB   = 4'd8,
		OP_VAND   = 4'd9,
		// Scalar rd gets the element sum of vector rs1, mod 256
		OP_VSUM   = 4'd10
	} op_e;

endpackage
